/* logic/mem_macros.svh */
// Size constants for the memory subsystem, included by every file that uses a MEM_ macro
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Word address and data widths
`define MEM_AN 24
`define MEM_DN 16

// Clients on the arbiter, external port is client 0
`define MEM_IN 2

// Words moved per granted burst
`define MEM_BURST 8

// RAM size as a power of two, addresses wrap at the depth
`define MEM_DEPTH_LOG2 8
`define MEM_DEPTH (1 << `MEM_DEPTH_LOG2)

`endif

/* logic/mem_pkg.sv */
// Types shared by the memory subsystem, referenced by scoped name from each module
`include "mem_macros.svh"

package mem_pkg;

typedef logic [`MEM_AN-1:0] addr_t;
typedef logic [`MEM_DN-1:0] data_t;

// One bit per client, one-hot where it means a grant
typedef logic [`MEM_IN-1:0] client_t;

// Word index inside a burst
typedef logic [$clog2(`MEM_BURST)-1:0] beat_t;

// Command a client presents with its req
typedef struct packed {
	logic wr;
	addr_t addr;
	data_t data;
} mem_req_t;

// Built-in test sequencer
typedef enum logic [2:0] {
	test_idle,
	test_write,
	test_read,
	test_next,
	test_done
} test_state_t;

endpackage

/* logic/burst_counter.sv */
// Beat counter for one burst, used by the memory controller and the test client
`timescale 1ns/10ps
`include "mem_macros.svh"

module burst_counter (
	input logic CLOCK_50,
	input logic reset,
	input logic start,
	input logic step,
	output mem_pkg::beat_t beat,
	output logic busy,
	output logic last
);

assign last = busy && (beat == mem_pkg::beat_t'(`MEM_BURST - 1));

// Start wins over step, so a new burst can begin on the last beat
always_ff @(posedge CLOCK_50) begin
	if (reset) begin
		beat <= '0;
		busy <= 1'b0;
	end else if (start) begin
		beat <= '0;
		busy <= 1'b1;
	end else if (step && busy) begin
		// Wraps back to zero after the last beat
		beat <= beat + 1'b1;
		if (last)
			busy <= 1'b0;
	end
end

endmodule

/* logic/reset_ctrl.sv */
// Reset synchronizer for the memory, holding the clients in reset until the memory is ready
`timescale 1ns/10ps

module reset_ctrl (
	input logic CLOCK_50,
	input logic reset,
	input logic mem_ready,
	output logic mem_reset,
	output logic client_reset
);

logic reset_meta;

// Two stages on the external reset
always_ff @(posedge CLOCK_50) begin
	reset_meta <= reset;
	mem_reset <= reset_meta;
end

// Clients wait for the clear sweep to finish
always_ff @(posedge CLOCK_50) begin
	if (mem_reset)
		client_reset <= 1'b1;
	else
		client_reset <= !mem_ready;
end

endmodule

/* logic/mem_arbiter.sv */
// Round-robin arbiter giving the memory to one client per burst and steering read data back
`timescale 1ns/10ps
`include "mem_macros.svh"

module mem_arbiter (
	input logic CLOCK_50,
	input logic reset,
	input mem_pkg::client_t client_req,
	input mem_pkg::mem_req_t client_cmd [`MEM_IN],
	output mem_pkg::client_t client_ack,
	output mem_pkg::client_t client_valid,
	output logic mem_req,
	output mem_pkg::mem_req_t mem_cmd,
	input logic mem_ack,
	input logic mem_rvalid,
	input logic mem_done
);

localparam int IW = $clog2(`MEM_IN);

mem_pkg::client_t grant;
mem_pkg::client_t pick;
mem_pkg::client_t rd_owner;
mem_pkg::client_t rd_owner_q;
logic [IW-1:0] cur_idx;
logic [IW-1:0] pick_idx;
logic rd_ack;
logic rd_ack_q;

// Nearest requester after the current one wins, current one comes last
always_comb begin
	int idx;
	pick = '0;
	pick_idx = cur_idx;
	for (int i = `MEM_IN; i > 0; i--) begin
		idx = (int'(cur_idx) + i) % `MEM_IN;
		if (client_req[idx]) begin
			pick = mem_pkg::client_t'(1) << idx;
			pick_idx = IW'(idx);
		end
	end
end

// Grant held until the memory has taken the whole burst
always_ff @(posedge CLOCK_50) begin
	if (reset) begin
		grant <= '0;
		cur_idx <= '0;
	end else if (grant == '0) begin
		grant <= pick;
		cur_idx <= pick_idx;
	end else if (mem_done) begin
		grant <= '0;
	end
end

assign mem_req = |(client_req & grant);
assign mem_cmd = client_cmd[cur_idx];
assign client_ack = mem_ack ? grant : '0;

assign rd_ack = mem_ack && !mem_cmd.wr;

// Owner moves to the output side just before the first word of its burst,
// after the previous burst has drained
always_ff @(posedge CLOCK_50) begin
	if (reset) begin
		rd_ack_q <= 1'b0;
		rd_owner <= '0;
		rd_owner_q <= '0;
	end else begin
		rd_ack_q <= rd_ack;
		if (rd_ack)
			rd_owner <= grant;
		if (rd_ack_q)
			rd_owner_q <= rd_owner;
	end
end

assign client_valid = mem_rvalid ? rd_owner_q : '0;

endmodule

/* logic/memory_ctrl.sv */
// On-chip burst RAM with a clear sweep after reset, serving one arbitrated client at a time
`timescale 1ns/10ps
`include "mem_macros.svh"

module memory_ctrl (
	input logic CLOCK_50,
	input logic reset,
	input logic req,
	input mem_pkg::mem_req_t cmd,
	output logic ack,
	output logic done,
	output logic rvalid,
	output mem_pkg::data_t rdata,
	output logic ready
);

localparam int AW = `MEM_DEPTH_LOG2;

mem_pkg::data_t ram [`MEM_DEPTH];

logic clearing;
logic [AW-1:0] clear_addr;
logic [AW-1:0] wr_addr;
logic [AW-1:0] rd_addr;
mem_pkg::addr_t wr_base;
mem_pkg::addr_t rd_base;

logic seq_start;
logic wr_ack;
logic rd_ack;
mem_pkg::beat_t seq_beat;
logic seq_busy;
logic seq_last;
mem_pkg::beat_t rd_beat;
logic rd_busy;
logic rd_last;

// Write burst takes one setup cycle, then one word per ack
assign seq_start = ready && req && cmd.wr && !seq_busy;
assign wr_ack = ready && req && cmd.wr && seq_busy;
// A read is taken whole once the previous one is on its last word
assign rd_ack = ready && req && !cmd.wr && !seq_busy && (!rd_busy || rd_last);

assign ack = wr_ack || rd_ack;
assign done = (wr_ack && seq_last) || rd_ack;

assign wr_addr = wr_base[AW-1:0] + AW'(seq_beat);
assign rd_addr = rd_base[AW-1:0] + AW'(rd_beat);

burst_counter seq_cnt (
	.CLOCK_50(CLOCK_50),
	.reset(reset),
	.start(seq_start),
	.step(wr_ack),
	.beat(seq_beat),
	.busy(seq_busy),
	.last(seq_last)
);

// Paces the read stream, one address per cycle
burst_counter rd_cnt (
	.CLOCK_50(CLOCK_50),
	.reset(reset),
	.start(rd_ack),
	.step(rd_busy),
	.beat(rd_beat),
	.busy(rd_busy),
	.last(rd_last)
);

always_ff @(posedge CLOCK_50) begin
	if (seq_start)
		wr_base <= cmd.addr;
	if (rd_ack)
		rd_base <= cmd.addr;
end

// Clear sweep has the write port until ready
always_ff @(posedge CLOCK_50) begin
	if (clearing)
		ram[clear_addr] <= '0;
	else if (wr_ack)
		ram[wr_addr] <= cmd.data;
	rdata <= ram[rd_addr];
end

always_ff @(posedge CLOCK_50) begin
	if (reset) begin
		clearing <= 1'b1;
		clear_addr <= '0;
		ready <= 1'b0;
		rvalid <= 1'b0;
	end else begin
		rvalid <= rd_busy;
		if (clearing) begin
			clear_addr <= clear_addr + 1'b1;
			if (clear_addr == '1) begin
				clearing <= 1'b0;
				ready <= 1'b1;
			end
		end
	end
end

endmodule

/* logic/mem_test.sv */
// Memory test client that writes an address pattern in bursts over a range and reads it back
`timescale 1ns/10ps
`include "mem_macros.svh"

module mem_test (
	input logic CLOCK_50,
	input logic reset,
	input logic start,
	input logic invert,
	input mem_pkg::addr_t base,
	input mem_pkg::addr_t words,
	output logic req,
	output mem_pkg::mem_req_t cmd,
	input logic ack,
	input logic valid,
	input mem_pkg::data_t rdata,
	output logic busy,
	output logic done,
	output logic fail
);

mem_pkg::test_state_t state;
mem_pkg::test_state_t state_next;
mem_pkg::addr_t burst_base;
mem_pkg::addr_t remaining;
mem_pkg::addr_t beat_addr;
mem_pkg::data_t expected;
mem_pkg::beat_t beat;
logic inv_q;
logic load;
logic cnt_start;
logic cnt_step;
logic cnt_busy;
logic cnt_last;

burst_counter cnt0 (
	.CLOCK_50(CLOCK_50),
	.reset(reset),
	.start(cnt_start),
	.step(cnt_step),
	.beat(beat),
	.busy(cnt_busy),
	.last(cnt_last)
);

// Beat is zero between bursts, so this is also the read base
assign beat_addr = burst_base + mem_pkg::addr_t'(beat);
assign expected = beat_addr[`MEM_DN-1:0] ^ {`MEM_DN{inv_q}};

always_comb begin
	cmd.wr = (state == mem_pkg::test_write);
	cmd.addr = beat_addr;
	cmd.data = expected;
end

// Read request drops once its single ack has started the counter
assign req = (state == mem_pkg::test_write) || (state == mem_pkg::test_read && !cnt_busy);
assign busy = (state != mem_pkg::test_idle) && (state != mem_pkg::test_done);
assign done = (state == mem_pkg::test_done);

always_comb begin
	state_next = state;
	load = 1'b0;
	cnt_start = 1'b0;
	cnt_step = 1'b0;
	case (state)
		mem_pkg::test_idle, mem_pkg::test_done: begin
			if (start) begin
				load = 1'b1;
				if (words != '0) begin
					state_next = mem_pkg::test_write;
					cnt_start = 1'b1;
				end else begin
					state_next = mem_pkg::test_done;
				end
			end
		end
		mem_pkg::test_write: begin
			cnt_step = ack;
			if (ack && cnt_last)
				state_next = mem_pkg::test_read;
		end
		mem_pkg::test_read: begin
			cnt_start = ack;
			cnt_step = valid;
			if (valid && cnt_last)
				state_next = mem_pkg::test_next;
		end
		mem_pkg::test_next: begin
			if (remaining <= mem_pkg::addr_t'(`MEM_BURST)) begin
				state_next = mem_pkg::test_done;
			end else begin
				state_next = mem_pkg::test_write;
				cnt_start = 1'b1;
			end
		end
		default: state_next = mem_pkg::test_idle;
	endcase
end

always_ff @(posedge CLOCK_50) begin
	if (reset) begin
		state <= mem_pkg::test_idle;
		fail <= 1'b0;
	end else begin
		state <= state_next;
		if (state == mem_pkg::test_read && valid && rdata != expected)
			fail <= 1'b1;
	end
end

// Range bookkeeping, one burst at a time
always_ff @(posedge CLOCK_50) begin
	if (load) begin
		burst_base <= base;
		remaining <= words;
		inv_q <= invert;
	end else if (state == mem_pkg::test_next) begin
		burst_base <= burst_base + mem_pkg::addr_t'(`MEM_BURST);
		remaining <= remaining - mem_pkg::addr_t'(`MEM_BURST);
	end
end

endmodule

/* logic/mem_system.sv */
// Top level of the memory subsystem with the external client port and the built-in test client
`timescale 1ns/10ps
`include "mem_macros.svh"

module mem_system (
	input logic CLOCK_50,
	input logic reset,
	input logic ext_req,
	input mem_pkg::mem_req_t ext_cmd,
	output logic ext_ack,
	output logic ext_valid,
	output mem_pkg::data_t rdata,
	input logic test_start,
	input logic test_invert,
	input mem_pkg::addr_t test_base,
	input mem_pkg::addr_t test_words,
	output logic test_busy,
	output logic test_done,
	output logic test_fail,
	output logic ready
);

// Arbiter slots
localparam int EXT = 0;
localparam int TEST = 1;

logic mem_reset;
logic client_reset;

mem_pkg::client_t client_req;
mem_pkg::client_t client_ack;
mem_pkg::client_t client_valid;
mem_pkg::mem_req_t client_cmd [`MEM_IN];

logic mem_req;
logic mem_ack;
logic mem_done;
logic mem_rvalid;
mem_pkg::mem_req_t mem_cmd;

reset_ctrl rst0 (
	.CLOCK_50(CLOCK_50),
	.reset(reset),
	.mem_ready(ready),
	.mem_reset(mem_reset),
	.client_reset(client_reset)
);

assign client_req[EXT] = ext_req;
assign client_cmd[EXT] = ext_cmd;
assign ext_ack = client_ack[EXT];
assign ext_valid = client_valid[EXT];

mem_arbiter arb0 (
	.CLOCK_50(CLOCK_50),
	.reset(mem_reset),
	.client_req(client_req),
	.client_cmd(client_cmd),
	.client_ack(client_ack),
	.client_valid(client_valid),
	.mem_req(mem_req),
	.mem_cmd(mem_cmd),
	.mem_ack(mem_ack),
	.mem_rvalid(mem_rvalid),
	.mem_done(mem_done)
);

memory_ctrl mem0 (
	.CLOCK_50(CLOCK_50),
	.reset(mem_reset),
	.req(mem_req),
	.cmd(mem_cmd),
	.ack(mem_ack),
	.done(mem_done),
	.rvalid(mem_rvalid),
	.rdata(rdata),
	.ready(ready)
);

mem_test test0 (
	.CLOCK_50(CLOCK_50),
	.reset(client_reset),
	.start(test_start),
	.invert(test_invert),
	.base(test_base),
	.words(test_words),
	.req(client_req[TEST]),
	.cmd(client_cmd[TEST]),
	.ack(client_ack[TEST]),
	.valid(client_valid[TEST]),
	.rdata(rdata),
	.busy(test_busy),
	.done(test_done),
	.fail(test_fail)
);

endmodule

/* sim/mem_system_tb.sv */
// Testbench for mem_system that applies a table of external bursts and test runs against a RAM model
`timescale 1ns/10ps
`include "mem_macros.svh"

module mem_system_tb;

typedef enum logic [1:0] {
	op_write,
	op_read,
	op_test_start,
	op_test_wait
} op_t;

// A nonzero seed reloads the LFSR before the row
typedef struct packed {
	op_t op;
	mem_pkg::addr_t base;
	logic [31:0] seed;
	logic [7:0] bursts;
	logic invert;
} row_t;

localparam int NUM_ROWS = 19;

logic CLOCK_50 = 1'b0;
logic reset;
logic ext_req;
mem_pkg::mem_req_t ext_cmd;
logic ext_ack;
logic ext_valid;
mem_pkg::data_t rdata;
logic test_start;
logic test_invert;
mem_pkg::addr_t test_base;
mem_pkg::addr_t test_words;
logic test_busy;
logic test_done;
logic test_fail;
logic ready;

row_t table_rows [NUM_ROWS];
mem_pkg::data_t shadow [`MEM_DEPTH];
logic [31:0] lfsr_state = 32'h7696ef80;
int error_count = 0;
int cycle_count = 0;
int cycle_limit = 0;

// Range of the test run in progress
mem_pkg::addr_t run_base;
int run_words;
logic run_invert;

mem_system uut (
	.CLOCK_50(CLOCK_50),
	.reset(reset),
	.ext_req(ext_req),
	.ext_cmd(ext_cmd),
	.ext_ack(ext_ack),
	.ext_valid(ext_valid),
	.rdata(rdata),
	.test_start(test_start),
	.test_invert(test_invert),
	.test_base(test_base),
	.test_words(test_words),
	.test_busy(test_busy),
	.test_done(test_done),
	.test_fail(test_fail),
	.ready(ready)
);

always #2 CLOCK_50 = ~CLOCK_50;

always @(posedge CLOCK_50) begin
	cycle_count <= cycle_count + 1;
	if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
		$display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
		$display("TESTS FAILED");
		$fatal(1, "Run timed out");
	end
end

task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
	if (actual !== expected) begin
		error_count++;
		$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
		$display("TESTS FAILED");
		$fatal(1, "Stopping at the first mismatch");
	end
endtask

// Taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic take_random_word(output mem_pkg::data_t w);
	for (int b = 0; b < `MEM_DN; b++) begin
		lfsr_state = lfsr_next(lfsr_state);
		w[b] = lfsr_state[0];
	end
endtask

// RAM index of word i of a burst wraps at the depth
function automatic int slot(input mem_pkg::addr_t base, input int i);
	return (int'(base) + i) % `MEM_DEPTH;
endfunction

function automatic row_t make_row(input op_t op, input mem_pkg::addr_t base,
		input logic [31:0] seed, input int bursts, input logic invert);
	row_t r;
	r.op = op;
	r.base = base;
	r.seed = seed;
	r.bursts = 8'(bursts);
	r.invert = invert;
	return r;
endfunction

task automatic ext_write(input mem_pkg::addr_t base);
	mem_pkg::data_t words [`MEM_BURST];
	mem_pkg::mem_req_t c;
	int i;
	for (i = 0; i < `MEM_BURST; i++) begin
		take_random_word(words[i]);
		shadow[slot(base, i)] = words[i];
	end
	c.wr = 1'b1;
	c.addr = base;
	c.data = words[0];
	@(posedge CLOCK_50);
	ext_req <= 1'b1;
	ext_cmd <= c;
	i = 0;
	while (i < `MEM_BURST) begin
		@(posedge CLOCK_50);
		if (ext_ack) begin
			i++;
			if (i == `MEM_BURST) begin
				ext_req <= 1'b0;
			end else begin
				c.addr = base + mem_pkg::addr_t'(i);
				c.data = words[i];
				ext_cmd <= c;
			end
		end
	end
endtask

task automatic ext_read(input mem_pkg::addr_t base);
	mem_pkg::mem_req_t c;
	c.wr = 1'b0;
	c.addr = base;
	c.data = '0;
	@(posedge CLOCK_50);
	ext_req <= 1'b1;
	ext_cmd <= c;
	do
		@(posedge CLOCK_50);
	while (ext_ack !== 1'b1);
	ext_req <= 1'b0;
	// First word is due two cycles after the ack
	@(posedge CLOCK_50);
	check_value("ext_valid", 0, ext_valid);
	for (int i = 0; i < `MEM_BURST; i++) begin
		@(posedge CLOCK_50);
		check_value("ext_valid", 1, ext_valid);
		check_value("rdata", shadow[slot(base, i)], rdata);
	end
endtask

task automatic start_test_run(input mem_pkg::addr_t base, input int bursts, input logic inv);
	run_base = base;
	run_words = bursts * `MEM_BURST;
	run_invert = inv;
	@(posedge CLOCK_50);
	test_start <= 1'b1;
	test_invert <= inv;
	test_base <= base;
	test_words <= mem_pkg::addr_t'(run_words);
	@(posedge CLOCK_50);
	test_start <= 1'b0;
	@(posedge CLOCK_50);
	check_value("test_busy", 1, test_busy);
endtask

task automatic finish_test_run();
	mem_pkg::addr_t a;
	mem_pkg::data_t p;
	while (test_done !== 1'b1)
		@(posedge CLOCK_50);
	check_value("test_fail", 0, test_fail);
	check_value("test_busy", 0, test_busy);
	// Pattern is the low data bits of the full address
	for (int i = 0; i < run_words; i++) begin
		a = run_base + mem_pkg::addr_t'(i);
		p = a[`MEM_DN-1:0];
		if (run_invert)
			p = ~p;
		shadow[slot(run_base, i)] = p;
	end
endtask

initial begin
	int n;
	int total_bursts;
	reset <= 1'b1;
	ext_req <= 1'b0;
	ext_cmd <= '0;
	test_start <= 1'b0;
	test_invert <= 1'b0;
	test_base <= '0;
	test_words <= '0;
	for (int i = 0; i < `MEM_DEPTH; i++)
		shadow[i] = '0;

	table_rows[0] = make_row(op_read, 24'h000080, 32'h0, 1, 1'b0);
	table_rows[1] = make_row(op_write, 24'h0000fc, 32'h7696ef80, 1, 1'b0);
	table_rows[2] = make_row(op_read, 24'h0000fc, 32'h0, 1, 1'b0);
	table_rows[3] = make_row(op_write, 24'h000010, 32'h0, 2, 1'b0);
	table_rows[4] = make_row(op_read, 24'h000010, 32'h0, 2, 1'b0);
	table_rows[5] = make_row(op_test_start, 24'h000040, 32'h0, 4, 1'b0);
	table_rows[6] = make_row(op_test_wait, 24'h000000, 32'h0, 0, 1'b0);
	table_rows[7] = make_row(op_read, 24'h000040, 32'h0, 4, 1'b0);
	table_rows[8] = make_row(op_test_start, 24'h000040, 32'h0, 4, 1'b1);
	table_rows[9] = make_row(op_test_wait, 24'h000000, 32'h0, 0, 1'b0);
	table_rows[10] = make_row(op_read, 24'h000040, 32'h0, 4, 1'b0);
	// External traffic on 0x10 and 0xa0 while the test owns 0x40 to 0x9f
	table_rows[11] = make_row(op_test_start, 24'h000040, 32'h0, 12, 1'b0);
	table_rows[12] = make_row(op_write, 24'h0000a0, 32'h0, 2, 1'b0);
	table_rows[13] = make_row(op_read, 24'h0000a0, 32'h0, 2, 1'b0);
	table_rows[14] = make_row(op_read, 24'h000010, 32'h0, 1, 1'b0);
	table_rows[15] = make_row(op_write, 24'h0000b0, 32'h0, 1, 1'b0);
	table_rows[16] = make_row(op_read, 24'h0000a8, 32'h0, 2, 1'b0);
	table_rows[17] = make_row(op_test_wait, 24'h000000, 32'h0, 0, 1'b0);
	table_rows[18] = make_row(op_read, 24'h000040, 32'h0, 12, 1'b0);

	// A test burst is a write and a read
	total_bursts = 0;
	for (int r = 0; r < NUM_ROWS; r++) begin
		if (table_rows[r].op == op_test_start)
			total_bursts += 2 * int'(table_rows[r].bursts);
		else
			total_bursts += int'(table_rows[r].bursts);
	end
	cycle_limit = total_bursts * 40 + `MEM_DEPTH + 16;

	repeat (2) @(posedge CLOCK_50);
	reset <= 1'b0;

	// Ready rises DEPTH+2 edges after release and is seen one edge later
	n = 0;
	do begin
		@(posedge CLOCK_50);
		n++;
	end while (ready !== 1'b1 && n < `MEM_DEPTH + 8);
	check_value("ready", 1, ready);
	check_value("ready delay", `MEM_DEPTH + 3, n);
	check_value("ext_ack", 0, ext_ack);
	check_value("ext_valid", 0, ext_valid);
	check_value("test_done", 0, test_done);
	check_value("test_fail", 0, test_fail);
	repeat (2) @(posedge CLOCK_50);

	for (int r = 0; r < NUM_ROWS; r++) begin
		if (table_rows[r].seed != 32'h0)
			lfsr_state = table_rows[r].seed;
		case (table_rows[r].op)
			op_write: begin
				for (int b = 0; b < int'(table_rows[r].bursts); b++)
					ext_write(table_rows[r].base + mem_pkg::addr_t'(b * `MEM_BURST));
			end
			op_read: begin
				for (int b = 0; b < int'(table_rows[r].bursts); b++)
					ext_read(table_rows[r].base + mem_pkg::addr_t'(b * `MEM_BURST));
			end
			op_test_start: begin
				start_test_run(table_rows[r].base, int'(table_rows[r].bursts),
					table_rows[r].invert);
			end
			default: finish_test_run();
		endcase
	end

	repeat (4) @(posedge CLOCK_50);
	if (error_count == 0)
		$display("TESTS PASSED");
	else
		$display("TESTS FAILED");
	$finish;
end

endmodule

/* tb.f */
+incdir+logic
logic/mem_pkg.sv
logic/burst_counter.sv
logic/reset_ctrl.sv
logic/mem_arbiter.sv
logic/memory_ctrl.sv
logic/mem_test.sv
logic/mem_system.sv
sim/mem_system_tb.sv
